// File: Makefile
VERILATOR ?= verilator
TOP ?= raster_setup_tb
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing --assert
SOURCES := $(wildcard design/*.sv sim/*.sv)

.PHONY: all run lint clean

all: run

run: $(OBJ_DIR)/V$(TOP)
	$(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: design/attr_tri_if.sv
`timescale 1ns/1ps

interface attr_tri_if;
    import raster_pkg::*;

    logic valid;
    logic ready;
    attributed_triangle_t data;
    triangle_metadata_t metadata; // Travels beside data, not inside it.

    modport source (
        output valid,
        output data,
        output metadata,
        input  ready
    );

    modport sink (
        input  valid,
        input  data,
        input  metadata,
        output ready
    );

endinterface

// File: design/fixed_recip_div.sv
`timescale 1ns/1ps

module fixed_recip_div #(
    parameter int DIV_BITS = 32
) (
    input  logic clk,
    input  logic rstn,
    input  logic divisor_valid,
    input  raster_pkg::fixed_t divisor,
    output logic result_valid,
    output raster_pkg::fixed_t result
);
    import raster_pkg::*;

    localparam int CNT_W = $clog2(DIV_BITS + 1);
    localparam int EXT_W = DIV_BITS + FIXED_WIDTH;
    localparam int SHIFT_DN = (DIV_BITS > FIXED_WIDTH) ? DIV_BITS - FIXED_WIDTH : 0;
    localparam int SHIFT_UP = (DIV_BITS < FIXED_WIDTH) ? FIXED_WIDTH - DIV_BITS : 0;
    localparam logic [FIXED_WIDTH-1:0] SAT_MAX = {1'b0, {(FIXED_WIDTH-1){1'b1}}};

    logic busy;
    logic [CNT_W-1:0] step_cnt;
    logic last_step;
    logic negative;
    logic [FIXED_WIDTH-1:0] magnitude;
    logic [FIXED_WIDTH-1:0] rem;
    logic [DIV_BITS-1:0] quot;

    logic [FIXED_WIDTH:0] rem_shift;
    logic [FIXED_WIDTH:0] rem_diff;
    logic fits;
    logic [FIXED_WIDTH-1:0] rem_next;
    logic [DIV_BITS-1:0] quot_next;
    logic [EXT_W-1:0] quot_ext;
    logic [EXT_W-1:0] quot_scaled;
    logic saturate;
    logic [FIXED_WIDTH-1:0] mag_result;

    // One restoring step per cycle.
    assign rem_shift = {rem, 1'b0};
    assign rem_diff = rem_shift - {1'b0, magnitude};
    assign fits = (rem_shift >= {1'b0, magnitude});
    assign rem_next = fits ? rem_diff[FIXED_WIDTH-1:0] : rem_shift[FIXED_WIDTH-1:0];
    assign quot_next = {quot[DIV_BITS-2:0], fits};

    // Bring 2^DIV_BITS / d back to the 2^32 / d scale.
    assign quot_ext = {{FIXED_WIDTH{1'b0}}, quot_next};
    assign quot_scaled = (quot_ext >> SHIFT_DN) << SHIFT_UP;
    assign saturate = (magnitude[FIXED_WIDTH-1:1] == '0) ||  // Divisor of 0 or 1.
                      (|quot_scaled[EXT_W-1:FIXED_WIDTH-1]);
    assign mag_result = saturate ? SAT_MAX : quot_scaled[FIXED_WIDTH-1:0];

    assign last_step = busy && (step_cnt == CNT_W'(DIV_BITS - 1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy <= 1'b0;
            step_cnt <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= last_step;
            if (divisor_valid) begin
                busy <= 1'b1;
                step_cnt <= '0;
            end else if (busy) begin
                step_cnt <= step_cnt + 1'b1;
                if (last_step) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (divisor_valid) begin
            negative <= divisor.raw[FIXED_WIDTH-1];
            magnitude <= divisor.raw[FIXED_WIDTH-1] ? -divisor.raw : divisor.raw;
            rem <= FIXED_WIDTH'(1); // Leading one of the dividend.
            quot <= '0;
        end else if (busy) begin
            rem <= rem_next;
            quot <= quot_next;
        end
        if (last_step) begin
            result.raw <= negative ? -mag_result : mag_result;
        end
    end

endmodule

// File: design/raster_pkg.sv
package raster_pkg;

    localparam int FIXED_WIDTH = 32;
    localparam int FRAC_BITS = 16;
    localparam int INT_BITS = FIXED_WIDTH - FRAC_BITS;

    typedef struct packed {
        logic signed [INT_BITS-1:0] int_part; // Whole pixels.
        logic [FRAC_BITS-1:0] frac;
    } fixed_parts_t;

    // One Q16.16 word, seen as a number or as a pixel coordinate.
    typedef union packed {
        logic signed [FIXED_WIDTH-1:0] raw;
        fixed_parts_t parts;
    } fixed_t;

    typedef struct packed {
        fixed_t x;
        fixed_t y;
    } position_t;

    typedef struct packed {
        position_t position;
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    typedef struct packed {
        logic [7:0] id;
        logic last; // Last triangle of the mesh.
    } triangle_metadata_t;

    typedef struct packed {
        triangle_t triangle;
        fixed_t area_inv;
    } attributed_triangle_t;

    typedef struct packed {
        logic [INT_BITS-1:0] x_min;
        logic [INT_BITS-1:0] y_min;
        logic [INT_BITS-1:0] x_max;
        logic [INT_BITS-1:0] y_max;
    } bbox_t;

    function automatic fixed_t add(fixed_t a, fixed_t b);
        fixed_t r;
        r.raw = a.raw + b.raw;
        return r;
    endfunction

    function automatic fixed_t sub(fixed_t a, fixed_t b);
        fixed_t r;
        r.raw = a.raw - b.raw;
        return r;
    endfunction

    function automatic fixed_t mul(fixed_t a, fixed_t b);
        logic signed [2*FIXED_WIDTH-1:0] wa;
        logic signed [2*FIXED_WIDTH-1:0] wb;
        logic signed [2*FIXED_WIDTH-1:0] prod;
        logic signed [2*FIXED_WIDTH-1:0] shifted;
        fixed_t r;
        wa = {{FIXED_WIDTH{a.raw[FIXED_WIDTH-1]}}, a.raw};
        wb = {{FIXED_WIDTH{b.raw[FIXED_WIDTH-1]}}, b.raw};
        prod = wa * wb;
        shifted = prod >>> FRAC_BITS;
        r.raw = shifted[FIXED_WIDTH-1:0];
        return r;
    endfunction

    // Edge function of v0 against edge v1-v2, twice the signed area.
    function automatic fixed_t triangle_area2(position_t p0, position_t p1, position_t p2);
        fixed_t term0;
        fixed_t term1;
        fixed_t term2;
        term0 = mul(sub(p1.y, p2.y), p0.x);
        term1 = mul(sub(p2.y, p0.y), p1.x);
        term2 = mul(sub(p0.y, p1.y), p2.x);
        return add(add(term0, term1), term2);
    endfunction

endpackage

// File: design/raster_setup_top.sv
`timescale 1ns/1ps

module raster_setup_top #(
    parameter int SCREEN_WIDTH = 320,
    parameter int SCREEN_HEIGHT = 240,
    parameter int DIV_BITS = 32 // 32 or more for an exact reciprocal.
) (
    input  logic clk,
    input  logic rstn,

    input  logic in_valid,
    output logic in_ready,
    input  raster_pkg::triangle_t in_triangle,
    input  raster_pkg::triangle_metadata_t in_metadata,

    output logic out_valid,
    input  logic out_ready,
    output raster_pkg::triangle_t out_triangle,
    output raster_pkg::fixed_t out_area_inv,
    output raster_pkg::bbox_t out_bbox,
    output raster_pkg::triangle_metadata_t out_metadata
);

    attr_tri_if attr_link ();

    triangle_setup #(
        .DIV_BITS(DIV_BITS)
    ) setup0 (
        .clk(clk),
        .rstn(rstn),
        .triangle_s_valid(in_valid),
        .triangle_s_ready(in_ready),
        .triangle_s_data(in_triangle),
        .triangle_s_metadata(in_metadata),
        .attr_m(attr_link.source)
    );

    triangle_bbox #(
        .SCREEN_WIDTH(SCREEN_WIDTH),
        .SCREEN_HEIGHT(SCREEN_HEIGHT)
    ) bbox0 (
        .clk(clk),
        .rstn(rstn),
        .attr_s(attr_link.sink),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_triangle(out_triangle),
        .out_area_inv(out_area_inv),
        .out_bbox(out_bbox),
        .out_metadata(out_metadata)
    );

endmodule

// File: design/triangle_bbox.sv
`timescale 1ns/1ps

module triangle_bbox #(
    parameter int SCREEN_WIDTH = 320,
    parameter int SCREEN_HEIGHT = 240
) (
    input  logic clk,
    input  logic rstn,
    attr_tri_if.sink attr_s,
    output logic out_valid,
    input  logic out_ready,
    output raster_pkg::triangle_t out_triangle,
    output raster_pkg::fixed_t out_area_inv,
    output raster_pkg::bbox_t out_bbox,
    output raster_pkg::triangle_metadata_t out_metadata
);
    import raster_pkg::*;

    localparam int X_LIMIT = SCREEN_WIDTH - 1;
    localparam int Y_LIMIT = SCREEN_HEIGHT - 1;

    typedef logic signed [INT_BITS-1:0] coord_t;

    function automatic coord_t min3(coord_t a, coord_t b, coord_t c);
        coord_t m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic coord_t max3(coord_t a, coord_t b, coord_t c);
        coord_t m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    function automatic logic [INT_BITS-1:0] clamp(coord_t v, int limit);
        logic [INT_BITS-1:0] r;
        r = v;
        if (v < 0) begin
            r = '0;
        end else if (v > limit) begin
            r = limit[INT_BITS-1:0];
        end
        return r;
    endfunction

    coord_t x0, x1, x2;
    coord_t y0, y1, y2;
    bbox_t box_c;
    logic load;

    assign x0 = attr_s.data.triangle.v0.position.x.parts.int_part;
    assign x1 = attr_s.data.triangle.v1.position.x.parts.int_part;
    assign x2 = attr_s.data.triangle.v2.position.x.parts.int_part;
    assign y0 = attr_s.data.triangle.v0.position.y.parts.int_part;
    assign y1 = attr_s.data.triangle.v1.position.y.parts.int_part;
    assign y2 = attr_s.data.triangle.v2.position.y.parts.int_part;

    always_comb begin
        box_c.x_min = clamp(min3(x0, x1, x2), X_LIMIT);
        box_c.y_min = clamp(min3(y0, y1, y2), Y_LIMIT);
        box_c.x_max = clamp(max3(x0, x1, x2), X_LIMIT);
        box_c.y_max = clamp(max3(y0, y1, y2), Y_LIMIT);
    end

    // Slot takes a new entry when empty or draining this cycle.
    assign attr_s.ready = !out_valid || out_ready;
    assign load = attr_s.valid && attr_s.ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_triangle <= attr_s.data.triangle;
            out_area_inv <= attr_s.data.area_inv;
            out_bbox <= box_c;
            out_metadata <= attr_s.metadata;
        end
    end

endmodule

// File: design/triangle_setup.sv
`timescale 1ns/1ps

module triangle_setup #(
    parameter int DIV_BITS = 32
) (
    input  logic clk,
    input  logic rstn,
    input  logic triangle_s_valid,
    output logic triangle_s_ready,
    input  raster_pkg::triangle_t triangle_s_data,
    input  raster_pkg::triangle_metadata_t triangle_s_metadata,
    attr_tri_if.source attr_m
);
    import raster_pkg::*;

    typedef enum logic [2:0] {
        IDLE,         // Ready for a triangle.
        CALC_AREA,    // Edge function settles.
        LATCH_AREA,   // Area held, divider started.
        CALC_INVERSE, // Divider running.
        DONE          // Waiting for the sink.
    } setup_state_t;

    setup_state_t state;
    setup_state_t state_next;

    triangle_t triangle_q;
    triangle_metadata_t metadata_q;
    fixed_t area_c;
    fixed_t area_r;
    fixed_t area_inv;
    logic area_inv_valid;
    logic divisor_valid;
    logic accept;

    assign triangle_s_ready = (state == IDLE);
    assign attr_m.valid = (state == DONE);
    assign accept = triangle_s_valid && triangle_s_ready;
    assign divisor_valid = (state == LATCH_AREA);

    assign area_c = triangle_area2(
        triangle_q.v0.position,
        triangle_q.v1.position,
        triangle_q.v2.position
    );

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            triangle_q <= triangle_s_data;
            metadata_q <= triangle_s_metadata;
        end
        if (state == CALC_AREA) begin
            area_r <= area_c;
        end
        if ((state == CALC_INVERSE) && area_inv_valid) begin
            attr_m.data.triangle <= triangle_q;
            attr_m.data.area_inv <= area_inv;
            attr_m.metadata <= metadata_q;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    state_next = CALC_AREA;
                end
            end
            CALC_AREA: begin
                state_next = LATCH_AREA;
            end
            LATCH_AREA: begin
                state_next = CALC_INVERSE;
            end
            CALC_INVERSE: begin
                if (area_inv_valid) begin
                    state_next = DONE;
                end
            end
            DONE: begin
                if (attr_m.ready) begin
                    state_next = IDLE; // Handshake, since valid is high here.
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    fixed_recip_div #(
        .DIV_BITS(DIV_BITS)
    ) divider0 (
        .clk(clk),
        .rstn(rstn),
        .divisor_valid(divisor_valid),
        .divisor(area_r),
        .result_valid(area_inv_valid),
        .result(area_inv)
    );

endmodule

// File: filelist.f
design/raster_pkg.sv
design/attr_tri_if.sv
design/fixed_recip_div.sv
design/triangle_setup.sv
design/triangle_bbox.sv
design/raster_setup_top.sv
sim/raster_setup_sva.sv
sim/raster_setup_tb.sv

// File: sim/raster_setup_sva.sv
`timescale 1ns/1ps

module raster_setup_sva (
    input logic clk,
    input logic rstn,
    input logic in_valid,
    input logic in_ready,
    input logic out_valid,
    input logic out_ready,
    input raster_pkg::triangle_t out_triangle,
    input raster_pkg::fixed_t out_area_inv,
    input raster_pkg::bbox_t out_bbox,
    input raster_pkg::triangle_metadata_t out_metadata
);

    int in_flight; // Accepted but not yet delivered.

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            in_flight <= 0;
        end else begin
            in_flight <= in_flight + int'(in_valid && in_ready)
                         - int'(out_valid && out_ready);
        end
    end

    hold_under_backpressure: assert property (@(posedge clk) disable iff (!rstn)
        out_valid && !out_ready |=> out_valid && $stable(out_triangle)
            && $stable(out_area_inv) && $stable(out_bbox) && $stable(out_metadata))
        else $error("Output stream changed while out_ready was low");

    state_after_reset: assert property (@(posedge clk) $rose(rstn) |-> !out_valid && in_ready)
        else $error("Wrong handshake state after reset release");

    output_needs_input: assert property (@(posedge clk) disable iff (!rstn)
        out_valid && out_ready |-> in_flight > 0)
        else $error("Output handshake without an accepted triangle");

endmodule

// File: sim/raster_setup_tb.sv
`timescale 1ns/1ps

module raster_setup_tb;
    import raster_pkg::*;

    localparam int DIV_BITS = 32;
    localparam int SCREEN_WIDTH = 320;
    localparam int SCREEN_HEIGHT = 240;
    localparam int RANDOM_TRIANGLES = 60;
    localparam int WATCHDOG_NS = 200 * (DIV_BITS + 10) * 10;
    localparam int DRAIN_CYCLES = 4 * (DIV_BITS + 10);

    typedef struct packed {
        triangle_t triangle;
        fixed_t area_inv;
        bbox_t bbox;
        triangle_metadata_t metadata;
    } expected_t;

    logic clk;
    logic rstn;
    logic in_valid;
    logic in_ready;
    triangle_t in_triangle;
    triangle_metadata_t in_metadata;
    logic out_valid;
    logic out_ready;
    triangle_t out_triangle;
    fixed_t out_area_inv;
    bbox_t out_bbox;
    triangle_metadata_t out_metadata;

    expected_t expected_q[$];
    int seed = 26821;
    int next_id = 0;

    raster_setup_top #(
        .SCREEN_WIDTH(SCREEN_WIDTH),
        .SCREEN_HEIGHT(SCREEN_HEIGHT),
        .DIV_BITS(DIV_BITS)
    ) dut0 (.*);

    bind raster_setup_top raster_setup_sva sva0 (
        .clk(clk),
        .rstn(rstn),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_triangle(out_triangle),
        .out_area_inv(out_area_inv),
        .out_bbox(out_bbox),
        .out_metadata(out_metadata)
    );

    // Reciprocal model: floor(2^32 / |d|) with saturation, sign of d.
    function automatic fixed_t recip_ref(fixed_t divisor);
        logic signed [63:0] value;
        logic [63:0] mag;
        logic [63:0] quot;
        fixed_t r;
        value = {{32{divisor.raw[31]}}, divisor.raw};
        mag = (value < 0) ? -value : value;
        quot = (mag == 0) ? 64'h7FFF_FFFF : (64'h1_0000_0000 / mag);
        if (quot > 64'h7FFF_FFFF) begin
            quot = 64'h7FFF_FFFF;
        end
        r.raw = (value < 0) ? -quot[31:0] : quot[31:0];
        return r;
    endfunction

    function automatic logic [INT_BITS-1:0] clamp_ref(int v, int limit);
        int c;
        c = (v < 0) ? 0 : ((v > limit) ? limit : v);
        return c[INT_BITS-1:0];
    endfunction

    function automatic bbox_t bbox_ref(triangle_t t);
        int xs[3];
        int ys[3];
        int x_lo, x_hi, y_lo, y_hi;
        bbox_t b;
        xs[0] = int'(t.v0.position.x.parts.int_part);
        xs[1] = int'(t.v1.position.x.parts.int_part);
        xs[2] = int'(t.v2.position.x.parts.int_part);
        ys[0] = int'(t.v0.position.y.parts.int_part);
        ys[1] = int'(t.v1.position.y.parts.int_part);
        ys[2] = int'(t.v2.position.y.parts.int_part);
        x_lo = xs[0];
        x_hi = xs[0];
        y_lo = ys[0];
        y_hi = ys[0];
        for (int i = 1; i < 3; i++) begin
            x_lo = (xs[i] < x_lo) ? xs[i] : x_lo;
            x_hi = (xs[i] > x_hi) ? xs[i] : x_hi;
            y_lo = (ys[i] < y_lo) ? ys[i] : y_lo;
            y_hi = (ys[i] > y_hi) ? ys[i] : y_hi;
        end
        b.x_min = clamp_ref(x_lo, SCREEN_WIDTH - 1);
        b.x_max = clamp_ref(x_hi, SCREEN_WIDTH - 1);
        b.y_min = clamp_ref(y_lo, SCREEN_HEIGHT - 1);
        b.y_max = clamp_ref(y_hi, SCREEN_HEIGHT - 1);
        return b;
    endfunction

    function automatic expected_t model_triangle(triangle_t t, triangle_metadata_t m);
        expected_t e;
        e.triangle = t;
        e.area_inv = recip_ref(triangle_area2(t.v0.position, t.v1.position, t.v2.position));
        e.bbox = bbox_ref(t);
        e.metadata = m;
        return e;
    endfunction

    function automatic vertex_t vertex_at(int x, int y, logic [15:0] fx, logic [15:0] fy);
        vertex_t v;
        v.position.x.parts.int_part = 16'(x);
        v.position.x.parts.frac = fx;
        v.position.y.parts.int_part = 16'(y);
        v.position.y.parts.frac = fy;
        return v;
    endfunction

    function automatic triangle_t make_triangle(int x0, int y0, int x1, int y1, int x2, int y2);
        triangle_t t;
        t.v0 = vertex_at(x0, y0, 16'h0, 16'h0);
        t.v1 = vertex_at(x1, y1, 16'h0, 16'h0);
        t.v2 = vertex_at(x2, y2, 16'h0, 16'h0);
        return t;
    endfunction

    function automatic int rand_range(int lo, int span);
        return lo + int'({$random(seed)} % span);
    endfunction

    // Coordinates reach 64 pixels past every screen edge.
    function automatic vertex_t random_vertex();
        int x;
        int y;
        x = rand_range(-64, SCREEN_WIDTH + 128);
        y = rand_range(-64, SCREEN_HEIGHT + 128);
        return vertex_at(x, y, 16'($random(seed)), 16'($random(seed)));
    endfunction

    task automatic check_field(string name, logic [191:0] expected, logic [191:0] actual);
        assert (actual == expected) else begin
            $display("CHECK FAILED at %0t: %s expected %h, actual %h",
                     $time, name, expected, actual);
            $display("Test failed");
            $fatal(1, "Output mismatch.");
        end
    endtask

    // Called on a falling edge, returns on a falling edge.
    task automatic send_triangle(triangle_t t, logic last);
        triangle_metadata_t meta;
        meta.id = next_id[7:0];
        meta.last = last;
        in_triangle = t;
        in_metadata = meta;
        in_valid = 1'b1;
        while (!in_ready) begin
            @(negedge clk);
        end
        expected_q.push_back(model_triangle(t, meta)); // Taken on the next rising edge.
        next_id++;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Test failed");
        $fatal(1, "Watchdog expired before all triangles were delivered.");
    end

    always @(negedge clk) begin
        expected_t exp_tri;
        if (rstn) begin
            out_ready = ($random(seed) & 3) != 0;
            if (out_valid && out_ready) begin
                if (expected_q.size() == 0) begin
                    $display("Output handshake at %0t with no triangle pending", $time);
                    $display("Test failed");
                    $fatal(1, "Unexpected output triangle.");
                end
                exp_tri = expected_q.pop_front();
                check_field("out_triangle", 192'(exp_tri.triangle), 192'(out_triangle));
                check_field("out_area_inv", 192'(exp_tri.area_inv), 192'(out_area_inv));
                check_field("out_bbox", 192'(exp_tri.bbox), 192'(out_bbox));
                check_field("out_metadata", 192'(exp_tri.metadata), 192'(out_metadata));
            end
        end
    end

    initial begin
        triangle_t t;
        in_valid = 1'b0;
        in_triangle = '0;
        in_metadata = '0;
        out_ready = 1'b0;
        rstn = 1'b0;
        repeat (8) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        send_triangle(make_triangle(10, 10, 20, 20, 30, 30), 1'b0); // Collinear.
        send_triangle(make_triangle(0, 0, 50, 0, 0, 40), 1'b0);
        send_triangle(make_triangle(0, 0, 0, 40, 50, 0), 1'b0); // Opposite winding.
        send_triangle(make_triangle(-20, -5, 400, 100, 100, 300), 1'b0);
        for (int i = 0; i < RANDOM_TRIANGLES; i++) begin
            t.v0 = random_vertex();
            t.v1 = random_vertex();
            t.v2 = random_vertex();
            send_triangle(t, i == RANDOM_TRIANGLES - 1);
        end
        for (int i = 0; i < DRAIN_CYCLES && expected_q.size() != 0; i++) begin
            @(negedge clk);
        end
        repeat (10) @(negedge clk);
        if (expected_q.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "Accepted triangles were not delivered.");
        end
    end

endmodule
